//--- hdl/ipv4_tx.sv
`timescale 1ns/1ps

module ipv4_tx (
  input  logic                 clk,
  input  logic                 fsm_rst,
  input  udp_tx_pkg::ip_addr_t src_ip,
  input  logic                 ip_rdy,
  input  udp_tx_pkg::ip_addr_t ip_dst_ip,
  input  logic [15:0]          ip_len,
  input  logic                 udp_val,
  input  logic [7:0]           udp_dat,
  input  logic                 udp_eof,
  output logic                 ip_req,
  output logic                 tx_val,
  output logic [7:0]           tx_dat,
  output logic                 tx_sof,
  output logic                 tx_eof
);
  import udp_tx_pkg::*;

  ipv4_hdr_u   hdr;
  logic [15:0] ip_id;
  logic [18:0] part_a;
  logic [18:0] part_b;
  logic [18:0] sum_a;
  logic [18:0] sum_b;
  logic [19:0] sum_all;
  logic [16:0] fold1;
  logic [15:0] fold2;
  logic [4:0]  hidx; // Next header byte, counts down
  logic        sum_p1;
  logic        sum_p2;
  logic        hdr_act;
  logic        pld_act;
  logic        busy;
  logic        start;

  assign busy  = sum_p1 || sum_p2 || hdr_act || pld_act;
  assign start = ip_rdy && !busy;

  // First checksum stage, two halves of five words
  always_comb begin
    part_a = '0;
    part_b = '0;
    for (int i = 0; i < IPV4_HDR_WORDS / 2; i++) begin
      part_a = part_a + 19'(hdr.words[i]);
      part_b = part_b + 19'(hdr.words[i + IPV4_HDR_WORDS / 2]);
    end
  end

  // End-around carry, two folds cover the worst case
  assign sum_all = {1'b0, sum_a} + {1'b0, sum_b};
  assign fold1   = {1'b0, sum_all[15:0]} + {13'd0, sum_all[19:16]};
  assign fold2   = fold1[15:0] + {15'd0, fold1[16]};

  always_ff @(posedge clk) begin
    if (start) begin
      hdr.fields.ver    <= IPV4_VER;
      hdr.fields.ihl    <= IPV4_IHL;
      hdr.fields.qos    <= '0;
      hdr.fields.length <= ip_len;
      hdr.fields.id     <= ip_id;
      hdr.fields.zero   <= 1'b0;
      hdr.fields.df     <= 1'b0;
      hdr.fields.mf     <= 1'b0;
      hdr.fields.fo     <= '0;
      hdr.fields.ttl    <= IPV4_TTL;
      hdr.fields.proto  <= IPV4_PROTO_UDP;
      hdr.fields.chksum <= '0;
      hdr.fields.src_ip <= src_ip;
      hdr.fields.dst_ip <= ip_dst_ip;
    end
    if (sum_p1) begin
      sum_a <= part_a;
      sum_b <= part_b;
    end
    if (sum_p2) begin
      hdr.fields.chksum <= ~fold2;
      tx_dat            <= hdr.bytes[IPV4_HDR_LEN-1]; // Checksum not needed yet
    end else if (hdr_act) begin
      tx_dat <= hdr.bytes[hidx];
    end else if (pld_act) begin
      tx_dat <= udp_dat;
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      sum_p1  <= 1'b0;
      sum_p2  <= 1'b0;
      hdr_act <= 1'b0;
      pld_act <= 1'b0;
      hidx    <= '0;
      ip_req  <= 1'b0;
      ip_id   <= '0;
      tx_val  <= 1'b0;
      tx_sof  <= 1'b0;
      tx_eof  <= 1'b0;
    end else begin
      tx_val <= 1'b0;
      tx_sof <= 1'b0;
      tx_eof <= 1'b0;
      sum_p1 <= start;
      sum_p2 <= sum_p1;
      if (sum_p2) begin
        tx_val  <= 1'b1;
        tx_sof  <= 1'b1;
        hidx    <= 5'(IPV4_HDR_LEN - 2);
        hdr_act <= 1'b1;
      end
      if (hdr_act) begin
        tx_val <= 1'b1;
        hidx   <= hidx - 5'd1;
        if (hidx == 5'd1) ip_req <= 1'b1; // UDP byte 0 lands right after byte 19
        if (hidx == 5'd0) begin
          hdr_act <= 1'b0;
          pld_act <= 1'b1;
        end
      end
      if (pld_act) begin
        tx_val <= udp_val;
        tx_eof <= udp_eof;
        if (udp_eof) begin
          pld_act <= 1'b0;
          ip_req  <= 1'b0;
        end
      end
      if (tx_eof) ip_id <= ip_id + 16'd1;
    end
  end

endmodule

//--- hdl/udp_ipv4_tx_top.sv
`timescale 1ns/1ps

module udp_ipv4_tx_top (
  input  logic                 clk,
  input  logic                 fsm_rst,
  input  udp_tx_pkg::ip_addr_t src_ip,
  input  logic                 wr_val,
  input  logic [7:0]           wr_dat,
  input  logic                 wr_last,
  input  udp_tx_pkg::port_t    wr_src_port,
  input  udp_tx_pkg::port_t    wr_dst_port,
  input  udp_tx_pkg::ip_addr_t wr_dst_ip,
  output logic                 buf_full,
  output logic                 tx_val,
  output logic [7:0]           tx_dat,
  output logic                 tx_sof,
  output logic                 tx_eof
);
  import udp_tx_pkg::*;

  // Buffer to UDP
  logic        pld_rdy;
  port_t       pld_src_port;
  port_t       pld_dst_port;
  ip_addr_t    pld_dst_ip;
  logic [7:0]  pld_len;
  logic [7:0]  pld_dat;
  logic        pld_eof;
  logic        pld_req;

  // UDP to IPv4
  logic        ip_rdy;
  logic        ip_req;
  ip_addr_t    ip_dst_ip;
  logic [15:0] ip_len;
  logic        udp_val;
  logic [7:0]  udp_dat;
  logic        udp_eof;

  udp_pld_buf u_udp_pld_buf (
    .clk          (clk),
    .fsm_rst      (fsm_rst),
    .wr_val       (wr_val),
    .wr_dat       (wr_dat),
    .wr_last      (wr_last),
    .wr_src_port  (wr_src_port),
    .wr_dst_port  (wr_dst_port),
    .wr_dst_ip    (wr_dst_ip),
    .pld_req      (pld_req),
    .buf_full     (buf_full),
    .pld_rdy      (pld_rdy),
    .pld_src_port (pld_src_port),
    .pld_dst_port (pld_dst_port),
    .pld_dst_ip   (pld_dst_ip),
    .pld_len      (pld_len),
    .pld_dat      (pld_dat),
    .pld_eof      (pld_eof)
  );

  udp_tx u_udp_tx (
    .clk          (clk),
    .fsm_rst      (fsm_rst),
    .pld_rdy      (pld_rdy),
    .pld_src_port (pld_src_port),
    .pld_dst_port (pld_dst_port),
    .pld_dst_ip   (pld_dst_ip),
    .pld_len      (pld_len),
    .pld_dat      (pld_dat),
    .pld_eof      (pld_eof),
    .ip_req       (ip_req),
    .pld_req      (pld_req),
    .ip_rdy       (ip_rdy),
    .ip_dst_ip    (ip_dst_ip),
    .ip_len       (ip_len),
    .udp_val      (udp_val),
    .udp_dat      (udp_dat),
    .udp_eof      (udp_eof)
  );

  ipv4_tx u_ipv4_tx (
    .clk       (clk),
    .fsm_rst   (fsm_rst),
    .src_ip    (src_ip),
    .ip_rdy    (ip_rdy),
    .ip_dst_ip (ip_dst_ip),
    .ip_len    (ip_len),
    .udp_val   (udp_val),
    .udp_dat   (udp_dat),
    .udp_eof   (udp_eof),
    .ip_req    (ip_req),
    .tx_val    (tx_val),
    .tx_dat    (tx_dat),
    .tx_sof    (tx_sof),
    .tx_eof    (tx_eof)
  );

endmodule

//--- hdl/udp_pld_buf.sv
`timescale 1ns/1ps

module udp_pld_buf (
  input  logic                 clk,
  input  logic                 fsm_rst,
  input  logic                 wr_val,
  input  logic [7:0]           wr_dat,
  input  logic                 wr_last,
  input  udp_tx_pkg::port_t    wr_src_port,
  input  udp_tx_pkg::port_t    wr_dst_port,
  input  udp_tx_pkg::ip_addr_t wr_dst_ip,
  input  logic                 pld_req,
  output logic                 buf_full,
  output logic                 pld_rdy,
  output udp_tx_pkg::port_t    pld_src_port,
  output udp_tx_pkg::port_t    pld_dst_port,
  output udp_tx_pkg::ip_addr_t pld_dst_ip,
  output logic [7:0]           pld_len,
  output logic [7:0]           pld_dat,
  output logic                 pld_eof
);
  import udp_tx_pkg::*;

  logic [7:0]         mem [BUF_DEPTH];
  logic [BUF_AW:0]    wr_ptr;
  logic [BUF_AW:0]    wr_base; // Start of the datagram being written
  logic [BUF_AW:0]    rd_ptr;
  logic [BUF_AW:0]    used;
  logic [7:0]         wr_len;
  logic [7:0]         rd_cnt;
  logic [7:0]         len_q [BUF_SLOTS];
  port_t              src_q [BUF_SLOTS];
  port_t              dst_q [BUF_SLOTS];
  ip_addr_t           ip_q  [BUF_SLOTS];
  logic [SLOT_AW-1:0] ws;
  logic [SLOT_AW-1:0] rs;
  logic [SLOT_AW:0]   slot_cnt;
  logic               wr_acc;
  logic               push;
  logic               pop;
  logic               rd_act;
  logic               rd_done;

  // Only complete datagrams count, so a write in progress always fits
  assign used     = wr_base - rd_ptr;
  assign buf_full = (int'(slot_cnt) == BUF_SLOTS) ||
                    (int'(used) > BUF_DEPTH - MAX_PLD_LEN);
  assign wr_acc   = wr_val && !buf_full;
  assign push     = wr_acc && wr_last;
  assign pop      = pld_eof;
  assign rd_act   = pld_req && !rd_done;

  assign pld_rdy      = (slot_cnt != '0);
  assign pld_len      = len_q[rs];
  assign pld_src_port = src_q[rs];
  assign pld_dst_port = dst_q[rs];
  assign pld_dst_ip   = ip_q[rs];

  always_ff @(posedge clk) begin
    if (wr_acc) mem[wr_ptr[BUF_AW-1:0]] <= wr_dat;
    if (rd_act) pld_dat <= mem[rd_ptr[BUF_AW-1:0]];
    if (push) begin
      len_q[ws] <= wr_len + 8'd1; // Count includes the last byte
      src_q[ws] <= wr_src_port;
      dst_q[ws] <= wr_dst_port;
      ip_q[ws]  <= wr_dst_ip;
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      wr_ptr   <= '0;
      wr_base  <= '0;
      rd_ptr   <= '0;
      wr_len   <= '0;
      rd_cnt   <= '0;
      ws       <= '0;
      rs       <= '0;
      slot_cnt <= '0;
      rd_done  <= 1'b0;
      pld_eof  <= 1'b0;
    end else begin
      pld_eof <= 1'b0;
      if (wr_acc) begin
        wr_ptr <= wr_ptr + 1;
        wr_len <= wr_len + 8'd1;
        if (wr_last) begin
          wr_base <= wr_ptr + 1;
          wr_len  <= '0;
          ws      <= ws + 1;
        end
      end
      if (rd_act) begin
        rd_ptr <= rd_ptr + 1;
        if (rd_cnt == pld_len - 8'd1) begin // Last byte of this slot
          rd_cnt  <= '0;
          rd_done <= 1'b1;
          pld_eof <= 1'b1;
        end else begin
          rd_cnt <= rd_cnt + 8'd1;
        end
      end
      if (!pld_req) rd_done <= 1'b0;
      if (push && !pop) slot_cnt <= slot_cnt + 1;
      else if (pop && !push) slot_cnt <= slot_cnt - 1;
      if (pop) rs <= rs + 1;
    end
  end

endmodule

//--- hdl/udp_tx.sv
`timescale 1ns/1ps

module udp_tx (
  input  logic                 clk,
  input  logic                 fsm_rst,
  input  logic                 pld_rdy,
  input  udp_tx_pkg::port_t    pld_src_port,
  input  udp_tx_pkg::port_t    pld_dst_port,
  input  udp_tx_pkg::ip_addr_t pld_dst_ip,
  input  logic [7:0]           pld_len,
  input  logic [7:0]           pld_dat,
  input  logic                 pld_eof,
  input  logic                 ip_req,
  output logic                 pld_req,
  output logic                 ip_rdy,
  output udp_tx_pkg::ip_addr_t ip_dst_ip,
  output logic [15:0]          ip_len,
  output logic                 udp_val,
  output logic [7:0]           udp_dat,
  output logic                 udp_eof
);
  import udp_tx_pkg::*;

  udp_hdr_u    hdr;
  logic [7:0]  hdr_tx;
  logic [15:0] byte_cnt;
  logic        hdr_done;
  logic        clr;

  // Header and outgoing IPv4 metadata
  always_ff @(posedge clk) begin
    hdr_tx <= hdr.bytes[UDP_HDR_LEN-1];
    if (!ip_rdy && pld_rdy) begin
      hdr.fields.src_port <= pld_src_port;
      hdr.fields.dst_port <= pld_dst_port;
      hdr.fields.length   <= {8'h00, pld_len} + 16'(UDP_HDR_LEN);
      hdr.fields.chksum   <= '0; // Optional over IPv4
      ip_dst_ip           <= pld_dst_ip;
      ip_len              <= {8'h00, pld_len} + 16'(UDP_HDR_LEN + IPV4_HDR_LEN);
    end else if (ip_req && ip_rdy) begin
      hdr.bytes <= {hdr.bytes[UDP_HDR_LEN-2:0], 8'h00};
    end
  end

  always_ff @(posedge clk) begin
    if (clr) begin
      ip_rdy   <= 1'b0;
      udp_val  <= 1'b0;
      pld_req  <= 1'b0;
      hdr_done <= 1'b0;
      byte_cnt <= '0;
    end else begin
      if (udp_val) byte_cnt <= byte_cnt + 16'd1;
      if (!ip_rdy && pld_rdy) begin
        ip_rdy <= 1'b1;
      end else if (ip_req && ip_rdy) begin
        udp_val <= 1'b1;
        // Payload lags the request by one cycle
        if (byte_cnt == 16'(UDP_HDR_LEN - 2)) pld_req <= 1'b1;
      end
      if (byte_cnt == 16'(UDP_HDR_LEN - 1)) hdr_done <= 1'b1;
    end
  end

  assign udp_eof = udp_val && pld_eof;
  assign udp_dat = hdr_done ? pld_dat : hdr_tx;
  assign clr     = fsm_rst || udp_eof; // Ready for the next slot after eof

endmodule

//--- hdl/udp_tx_pkg.sv
package udp_tx_pkg;

  // Header sizes in bytes
  localparam int UDP_HDR_LEN    = 8;
  localparam int IPV4_HDR_LEN   = 20;
  localparam int IPV4_HDR_WORDS = IPV4_HDR_LEN / 2;

  // Fixed IPv4 field values
  localparam logic [3:0] IPV4_VER       = 4'd4;
  localparam logic [3:0] IPV4_IHL       = 4'd5; // 32-bit words, no options
  localparam logic [7:0] IPV4_TTL       = 8'd128;
  localparam logic [7:0] IPV4_PROTO_UDP = 8'd17;

  // Payload buffer
  localparam int BUF_DEPTH   = 512;
  localparam int BUF_AW      = $clog2(BUF_DEPTH);
  localparam int BUF_SLOTS   = 2;
  localparam int SLOT_AW     = $clog2(BUF_SLOTS);
  localparam int MAX_PLD_LEN = 255;

  typedef logic [3:0][7:0] ip_addr_t; // [3] is the first byte on the wire
  typedef logic [15:0]     port_t;

  typedef struct packed {
    port_t       src_port;
    port_t       dst_port;
    logic [15:0] length;
    logic [15:0] chksum;
  } udp_hdr_t;

  // Filled in by field, sent out by byte
  typedef union packed {
    udp_hdr_t                     fields;
    logic [UDP_HDR_LEN-1:0][7:0] bytes;
  } udp_hdr_u;

  typedef struct packed {
    logic [3:0]  ver;
    logic [3:0]  ihl;
    logic [7:0]  qos;
    logic [15:0] length;
    logic [15:0] id;
    logic        zero; // Reserved flag bit
    logic        df;
    logic        mf;
    logic [12:0] fo;
    logic [7:0]  ttl;
    logic [7:0]  proto;
    logic [15:0] chksum;
    ip_addr_t    src_ip;
    ip_addr_t    dst_ip;
  } ipv4_hdr_t;

  // Words feed the checksum, bytes feed the serializer
  typedef union packed {
    ipv4_hdr_t                          fields;
    logic [IPV4_HDR_WORDS-1:0][15:0]    words;
    logic [IPV4_HDR_LEN-1:0][7:0]       bytes;
  } ipv4_hdr_u;

endpackage

//--- run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f src.f --top-module udp_ipv4_tx_tb -o udp_sim \
  && ./obj_dir/udp_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or run error"; exit 1; }

cat sim.log
grep -qF '*** FAILED ***' sim.log && { echo "Simulation failed"; exit 1; }
grep -qF '*** PASSED ***' sim.log || { echo "No result in log"; exit 1; }
echo "Simulation passed"

//--- src.f
hdl/udp_tx_pkg.sv
hdl/udp_pld_buf.sv
hdl/udp_tx.sv
hdl/ipv4_tx.sv
hdl/udp_ipv4_tx_top.sv
test/udp_ipv4_tx_tb.sv

//--- test/udp_ipv4_tx_tb.sv
`timescale 1ns/1ps

module udp_ipv4_tx_tb;
  import udp_tx_pkg::*;

  localparam int DRIVE_DLY   = 1;
  localparam int TIMEOUT     = 2000; // Cycles of slack for two full packets ahead
  localparam int QUIET       = 300;
  localparam int ABORT_AFTER = 40;

  logic       clk;
  logic       fsm_rst;
  ip_addr_t   src_ip;
  logic       wr_val;
  logic [7:0] wr_dat;
  logic       wr_last;
  port_t      wr_src_port;
  port_t      wr_dst_port;
  ip_addr_t   wr_dst_ip;
  logic       buf_full;
  logic       tx_val;
  logic [7:0] tx_dat;
  logic       tx_sof;
  logic       tx_eof;

  // Expected datagrams in write order
  port_t       exp_src [$];
  port_t       exp_dst [$];
  ip_addr_t    exp_ip  [$];
  int          exp_len [$];
  logic [15:0] exp_id  [$];
  logic [7:0]  exp_pld [$];

  integer      seed = 14604;
  int          errors;
  int          tests;
  int          pending; // Written but not yet fully received
  logic [15:0] next_id;
  logic        skip_pkt;

  udp_ipv4_tx_top u_udp_ipv4_tx_top (.*);

  always #4 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $finish;
  endtask

  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp, inout int err);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
      err++;
    end
  endtask

  task automatic check_ipv4_hdr(input ipv4_hdr_u got, input ipv4_hdr_u exp, inout int err);
    compare_field("ipv4.ver", 32'(got.fields.ver), 32'(exp.fields.ver), err);
    compare_field("ipv4.ihl", 32'(got.fields.ihl), 32'(exp.fields.ihl), err);
    compare_field("ipv4.qos", 32'(got.fields.qos), 32'(exp.fields.qos), err);
    compare_field("ipv4.length", 32'(got.fields.length), 32'(exp.fields.length), err);
    compare_field("ipv4.id", 32'(got.fields.id), 32'(exp.fields.id), err);
    compare_field("ipv4.flags", 32'({got.fields.zero, got.fields.df, got.fields.mf}),
                  32'({exp.fields.zero, exp.fields.df, exp.fields.mf}), err);
    compare_field("ipv4.fo", 32'(got.fields.fo), 32'(exp.fields.fo), err);
    compare_field("ipv4.ttl", 32'(got.fields.ttl), 32'(exp.fields.ttl), err);
    compare_field("ipv4.proto", 32'(got.fields.proto), 32'(exp.fields.proto), err);
    compare_field("ipv4.chksum", 32'(got.fields.chksum), 32'(exp.fields.chksum), err);
    compare_field("ipv4.src_ip", got.fields.src_ip, exp.fields.src_ip, err);
    compare_field("ipv4.dst_ip", got.fields.dst_ip, exp.fields.dst_ip, err);
  endtask

  task automatic check_udp_hdr(input udp_hdr_u got, input udp_hdr_u exp, inout int err);
    compare_field("udp.src_port", 32'(got.fields.src_port), 32'(exp.fields.src_port), err);
    compare_field("udp.dst_port", 32'(got.fields.dst_port), 32'(exp.fields.dst_port), err);
    compare_field("udp.length", 32'(got.fields.length), 32'(exp.fields.length), err);
    compare_field("udp.chksum", 32'(got.fields.chksum), 32'(exp.fields.chksum), err);
  endtask

  task automatic check_byte(input int idx, input logic [7:0] got, input logic [7:0] exp,
                            inout int err);
    if (got !== exp) begin
      $display("mismatch tx_dat payload[%0d]: got 0x%h expected 0x%h", idx, got, exp);
      err++;
    end
  endtask

  // Ones' complement of the folded sum of all ten words
  function automatic logic [15:0] header_chksum(input ipv4_hdr_u h);
    logic [31:0] acc;
    acc = 32'd0;
    for (int i = 0; i < 10; i++) acc = acc + {16'd0, h.words[i]};
    while (acc[31:16] != 16'd0) acc = {16'd0, acc[15:0]} + {16'd0, acc[31:16]};
    return ~acc[15:0];
  endfunction

  task automatic collect_packet();
    ipv4_hdr_u   got_ip;
    ipv4_hdr_u   want_ip;
    udp_hdr_u    got_udp;
    udp_hdr_u    want_udp;
    logic [7:0]  pld [MAX_PLD_LEN];
    int          len;
    int          total;
    int          rcvd;
    int          err;
    logic [15:0] id;
    len      = exp_len.pop_front();
    id       = exp_id.pop_front();
    total    = len + 28;
    err      = 0;
    got_ip   = '0;
    got_udp  = '0;
    want_ip  = '0;
    want_udp = '0;
    want_ip.fields.ver    = 4'd4;
    want_ip.fields.ihl    = 4'd5;
    want_ip.fields.length = 16'(total);
    want_ip.fields.id     = id;
    want_ip.fields.ttl    = 8'd128;
    want_ip.fields.proto  = 8'd17;
    want_ip.fields.src_ip = src_ip;
    want_ip.fields.dst_ip = exp_ip.pop_front();
    want_ip.fields.chksum = header_chksum(want_ip);
    want_udp.fields.src_port = exp_src.pop_front();
    want_udp.fields.dst_port = exp_dst.pop_front();
    want_udp.fields.length   = 16'(len + 8);
    for (rcvd = 0; rcvd < total; rcvd++) begin
      if (rcvd > 0) @(negedge clk);
      if (!tx_val) begin
        $display("tx_val dropped at byte %0d of %0d", rcvd, total);
        err++;
        break;
      end
      compare_field("tx_sof", 32'(tx_sof), 32'(rcvd == 0), err);
      compare_field("tx_eof", 32'(tx_eof), 32'(rcvd == total - 1), err);
      if (rcvd < 20) got_ip.bytes[19 - rcvd] = tx_dat; // First byte on the wire is MSB
      else if (rcvd < 28) got_udp.bytes[27 - rcvd] = tx_dat;
      else pld[rcvd - 28] = tx_dat;
    end
    check_ipv4_hdr(got_ip, want_ip, err);
    check_udp_hdr(got_udp, want_udp, err);
    for (int k = 0; k < len; k++) begin
      if (k + 28 < rcvd) check_byte(k, pld[k], exp_pld.pop_front(), err);
      else void'(exp_pld.pop_front());
    end
    tests++;
    errors += err;
    pending--;
    if (err == 0) $display("datagram %0d len %0d id %0d ok", tests, len, id);
    else $display("datagram %0d len %0d id %0d: %0d errors", tests, len, id, err);
  endtask

  task automatic apply_reset();
    fsm_rst = 1'b1;
    repeat (5) @(posedge clk);
    #DRIVE_DLY;
    fsm_rst = 1'b0;
    compare_field("buf_full", 32'(buf_full), 32'd0, errors);
  endtask

  task automatic wait_buf_free();
    int n;
    n = 0;
    while (buf_full) begin
      wr_val = 1'b0;
      @(posedge clk);
      #DRIVE_DLY;
      n++;
      if (n > TIMEOUT) abort_run("timeout waiting for buf_full to clear");
    end
  endtask

  task automatic wait_sof();
    int n;
    n = 0;
    while (!tx_sof) begin
      @(posedge clk);
      #DRIVE_DLY;
      n++;
      if (n > TIMEOUT) abort_run("timeout waiting for tx_sof");
    end
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    while (pending != 0) begin
      @(posedge clk);
      #DRIVE_DLY;
      n++;
      if (n > 4 * TIMEOUT) abort_run("timeout waiting for outstanding datagrams");
    end
  endtask

  task automatic write_datagram(input port_t sp, input port_t dp, input ip_addr_t ip,
                                input int len, input bit expected);
    logic [7:0] b;
    if (expected) begin
      exp_src.push_back(sp);
      exp_dst.push_back(dp);
      exp_ip.push_back(ip);
      exp_len.push_back(len);
      exp_id.push_back(next_id);
      next_id++;
      pending++;
    end
    for (int i = 0; i < len; i++) begin
      b = 8'($random(seed));
      wait_buf_free();
      wr_val      = 1'b1;
      wr_dat      = b;
      wr_last     = (i == len - 1);
      wr_src_port = sp;
      wr_dst_port = dp;
      wr_dst_ip   = ip;
      if (expected) exp_pld.push_back(b);
      @(posedge clk);
      #DRIVE_DLY;
    end
    wr_val  = 1'b0;
    wr_last = 1'b0;
  endtask

  task automatic reset_during_packet(input port_t sp, input port_t dp, input ip_addr_t ip,
                                     input int len);
    int err;
    err = 0;
    wait_drained();
    skip_pkt = 1'b1;
    write_datagram(sp, dp, ip, len, 1'b0);
    wait_sof();
    repeat (ABORT_AFTER) @(posedge clk);
    #DRIVE_DLY;
    apply_reset();
    repeat (QUIET) begin
      @(negedge clk);
      if (tx_val && err == 0) begin
        $display("tx_val went high after reset with no datagram stored");
        err++;
      end
    end
    skip_pkt = 1'b0;
    next_id  = '0;
    tests++;
    errors += err;
    if (err == 0) $display("reset %0d mid-packet: output stayed quiet", tests);
    else $display("reset %0d mid-packet: partial packet resumed", tests);
  endtask

  initial begin : monitor
    int idle;
    idle = 0;
    forever begin
      @(negedge clk);
      if (tx_val && !tx_sof && !skip_pkt) begin
        $display("tx_val high outside a packet");
        errors++;
      end
      if (tx_sof && !skip_pkt) begin
        idle = 0;
        if (exp_len.size() == 0) begin
          $display("packet started with no datagram expected");
          errors++;
        end else begin
          collect_packet();
        end
      end else if (pending != 0) begin
        idle++;
        if (idle > TIMEOUT) abort_run("timeout waiting for an expected packet");
      end else begin
        idle = 0;
      end
    end
  end

  initial begin : stimulus
    int         fd;
    int         n;
    int         len;
    string      line;
    logic [7:0] cmd;
    port_t      sp;
    port_t      dp;
    ip_addr_t   ip;
    clk         = 1'b0;
    fsm_rst     = 1'b1;
    src_ip      = 32'hc0a80a0a;
    wr_val      = 1'b0;
    wr_dat      = '0;
    wr_last     = 1'b0;
    wr_src_port = '0;
    wr_dst_port = '0;
    wr_dst_ip   = '0;
    errors      = 0;
    tests       = 0;
    pending     = 0;
    next_id     = '0;
    skip_pkt    = 1'b0;
    apply_reset();
    fd = $fopen("test/udp_stim.txt", "r");
    if (fd == 0) abort_run("cannot open test/udp_stim.txt");
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.getc(0) == "#") continue;
      n = $sscanf(line, "%c %h %h %h %d", cmd, sp, dp, ip, len);
      if (n != 5 || len < 1 || len > MAX_PLD_LEN) begin
        $display("bad stimulus line: %s", line);
        errors++;
      end else if (cmd == "s") begin
        write_datagram(sp, dp, ip, len, 1'b1);
      end else if (cmd == "r") begin
        reset_during_packet(sp, dp, ip, len);
      end else begin
        $display("unknown command in stimulus line: %s", line);
        errors++;
      end
    end
    $fclose(fd);
    wait_drained();
    repeat (10) @(posedge clk);
    $display("tests %0d, errors %0d", tests, errors);
    if (errors == 0) $display("*** PASSED ***");
    else $display("*** FAILED ***");
    $finish;
  end

endmodule

//--- test/udp_stim.txt
# cmd src_port dst_port dst_ip len   (ports and IP in hex, payload length in decimal)
# s sends a datagram, r sends one and resets while it is on the wire
s 1234 0050 c0a80a01 1
s 4000 4001 c0a80a02 5
s 0400 0035 0a000001 64
s abcd 1234 c0a80164 255
s 0001 0002 c0a80165 3
s 1f90 1f91 c0a80166 17
s ffff 0000 ffffffff 255
s 8000 7fff 01020304 128
s 0035 c350 08080808 2
r 0101 0202 c0a80103 200
s 2222 3333 c0a80104 10
s 0d05 0e06 c0a80105 255
s 4444 5555 ac100001 1
s 6000 6001 ac100002 40
r 7000 7001 ac100003 150
s 9999 aaaa ac100004 7
s bbbb cccc ac100005 255
s dddd eeee ac100006 33
